// ==== dv/slice64Patterns.hex ====
// id ialu aAddr bAddr cin mode32 iss nCem nCen dIn yssIn checkEn expY expYss expCt
// ialu is dst<<6 | fn<<3 | src, expected values appear 2 edges after the row is driven
01 0DF 0 1 0 0 0000 1 1 0123456789ABCDEF 0 1 0123456789ABCDEF 0 0
02 0DF 0 2 0 0 0000 1 1 8000000000000001 0 1 8000000000000001 0 0
03 09C 1 1 0 0 0000 1 1 0000000000000000 0 1 0123456789ABCDEF 0 0
04 01F 0 0 0 0 0000 1 1 FEDCBA9876543210 0 1 FEDCBA9876543210 0 0
05 05A 0 0 0 0 0000 1 1 0000000000000000 0 1 FEDCBA9876543210 0 0
06 041 1 2 0 0 0000 0 0 0000000000000000 0 1 8123456789ABCDF0 0 0
07 05C 1 0 0 0 000C 1 1 0000000000000000 0 1 0123456789ABCDEF 4 1
08 05C 1 0 0 0 0004 1 1 0000000000000000 0 1 0123456789ABCDEF 4 1
09 05C 1 0 0 0 0005 1 1 0000000000000000 0 1 0123456789ABCDEF 4 0
10 0DF 0 3 0 0 0000 1 1 0000000100000000 0 1 0000000100000000 4 0
11 05C 3 0 0 1 0000 0 1 0000000000000000 0 1 0000000100000000 4 0
12 05C 3 0 0 0 0000 1 1 0000000000000000 0 1 0000000100000000 8 0
13 05C 3 0 0 0 0000 0 1 0000000000000000 0 1 0000000100000000 8 0
14 05C 3 0 0 0 0000 1 1 0000000000000000 0 1 0000000100000000 0 0
15 0DF 0 4 0 0 0000 1 1 8000000000000001 0 1 8000000000000001 0 0
16 1DC 4 5 0 0 0000 1 1 0000000000000000 0 1 8000000000000001 0 0
17 09C 5 5 0 0 0000 1 1 0000000000000000 0 1 0000000000000002 0 0
18 1DC 4 5 0 0 0080 1 1 0000000000000000 0 1 8000000000000001 0 0
19 09C 5 5 0 0 0000 1 1 0000000000000000 0 1 0000000000000003 0 0
20 15C 4 6 0 0 0040 1 1 0000000000000000 0 1 8000000000000001 0 0
21 09C 6 6 0 0 0000 1 1 0000000000000000 0 1 C000000000000000 0 0
22 15C 1 7 0 0 0100 1 1 0000000000000000 0 1 0123456789ABCDEF 0 0
23 09C 7 7 0 0 0000 1 1 0000000000000000 0 1 0091A2B3C4D5E6F7 0 0
24 05C 1 0 0 0 0010 0 1 0000000000000000 A 1 0123456789ABCDEF 0 0
25 05C 1 0 0 0 0008 1 1 0000000000000000 0 1 0123456789ABCDEF A 1

// ==== dv/tbSlice64Core.sv ====
`timescale 1ns/10ps
`default_nettype none

module tbSlice64Core
    import sliceCorePkg::*;
();

    localparam int numCols = 15;
    localparam int maxVec  = 64;

    logic                 clk;
    logic                 rstN;
    microWordT            microIn;
    logic [dataWidth-1:0] dIn;
    statusT               yssIn;
    logic [dataWidth-1:0] yOut;
    statusT               yssOut;
    logic                 ct;

    logic [63:0] patMem [0:numCols*maxVec-1];
    int          errorCount = 0;
    int          checkCount = 0;
    integer      seed = 39;

    slice64Core UUT (
        .clk(clk), .rstN(rstN), .microIn(microIn), .dIn(dIn), .yssIn(yssIn),
        .yOut(yOut), .yssOut(yssOut), .ct(ct)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Guard against a stuck run
    initial begin
        #100us;
        $display("Simulation did not finish within the time limit");
        $display("TESTS FAILED");
        $finish;
    end

    function automatic microWordT makeWord(input logic [8:0] ialu, input logic [3:0] a,
                                           input logic [3:0] b, input logic cin,
                                           input logic m32, input logic [12:0] iss,
                                           input logic nCem, input logic nCen);
        microWordT w;
        w = '{ialu: ialu, aAddr: a, bAddr: b, cin: cin, mode32: m32, iss: iss,
              nCem: nCem, nCen: nCen};
        return w;
    endfunction

    // 64-bit adder with carry out in bit 64
    function automatic logic [64:0] addModel(input logic [63:0] x, input logic [63:0] y,
                                             input logic cin);
        return {1'b0, x} + {1'b0, y} + {64'd0, cin};
    endfunction

    function automatic statusT flagsModel(input logic [63:0] x, input logic [63:0] y,
                                          input logic [64:0] s);
        statusT f;
        f.z   = (s[63:0] == 64'd0);
        f.n   = s[63];
        f.c   = s[64];
        // Same-sign operands giving a result of the other sign
        f.ovr = (x[63] == y[63]) && (s[63] != x[63]);
        return f;
    endfunction

    // Codes 0 to 7 test the micro status and 8 to 15 the machine status
    function automatic logic ctModel(input logic [3:0] code, input statusT micro,
                                     input statusT mach);
        statusT st;
        logic   res;
        st = (code >= 4'd8) ? mach : micro;
        case (code[2:0])
            3'd0:    res = st.z;
            3'd1:    res = !st.z;
            3'd2:    res = st.c;
            3'd3:    res = !st.c;
            3'd4:    res = st.n;
            3'd5:    res = !st.n;
            3'd6:    res = st.ovr;
            default: res = !st.ovr;
        endcase
        return res;
    endfunction

    task automatic checkValue(input string name, input logic [63:0] expVal,
                              input logic [63:0] actVal);
        checkCount++;
        assert (actVal === expVal) else begin
            $display("[FAIL] %s expected %h actual %h", name, expVal, actVal);
            errorCount++;
        end
    endtask

    task automatic drive(input microWordT mw, input logic [63:0] d, input statusT ys);
        @(posedge clk);
        microIn <= mw;
        dIn     <= d;
        yssIn   <= ys;
    endtask

    // One microword followed by NOPs until Y and its loaded status are out
    task automatic runOp(input microWordT mw, input logic [63:0] d, input statusT ys,
                         output logic [63:0] yRes, output statusT stRes,
                         output logic ctRes);
        drive(mw, d, ys);
        drive(nopMicroWord, '0, '0);
        @(posedge clk);
        @(negedge clk);
        yRes  = yOut;
        ctRes = ct;
        @(posedge clk);
        @(negedge clk);
        stRes = yssOut;
    endtask

    initial begin
        int          nVec;
        int          base;
        int          waitCount;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] x;
        logic [63:0] y;
        logic [63:0] yRes;
        logic [64:0] sumExp;
        logic [2:0]  fn;
        statusT      stRes;
        statusT      microExp;
        statusT      machExp;
        logic        ctRes;

        rstN    = 1'b0;
        microIn = nopMicroWord;
        dIn     = '0;
        yssIn   = '0;

        for (int i = 0; i < numCols * maxVec; i++) begin
            patMem[i] = '1;
        end
        $readmemh("dv/slice64Patterns.hex", patMem);
        nVec = 0;
        while (nVec < maxVec && patMem[nVec*numCols] !== '1) begin
            nVec++;
        end

        // Outputs held at zero while in reset
        repeat (7) @(posedge clk);
        @(negedge clk);
        checkValue("reset yOut", 64'd0, yOut);
        checkValue("reset yssOut", 64'd0, {60'd0, yssOut});
        checkValue("reset ct", 64'd0, {63'd0, ct});
        @(posedge clk);
        rstN <= 1'b1;

        waitCount = 0;
        while (rstN !== 1'b1 && waitCount < 20) begin
            @(posedge clk);
            waitCount++;
        end
        if (rstN !== 1'b1) begin
            $display("Reset was not released in time");
            errorCount++;
        end

        // NOP cycles leave status and CT cleared
        repeat (3) @(posedge clk);
        @(negedge clk);
        checkValue("nop yssOut", 64'd0, {60'd0, yssOut});
        checkValue("nop ct", 64'd0, {63'd0, ct});

        // Pattern replay with results checked 2 edges after driving
        for (int k = 0; k < nVec + 2; k++) begin
            @(posedge clk);
            if (k < nVec) begin
                base = k * numCols;
                microIn <= makeWord(patMem[base+1][8:0], patMem[base+2][3:0],
                                    patMem[base+3][3:0], patMem[base+4][0],
                                    patMem[base+5][0], patMem[base+6][12:0],
                                    patMem[base+7][0], patMem[base+8][0]);
                dIn     <= patMem[base+9];
                yssIn   <= patMem[base+10][3:0];
            end else begin
                microIn <= nopMicroWord;
                dIn     <= '0;
                yssIn   <= '0;
            end
            @(negedge clk);
            if (k >= 2 && patMem[(k-2)*numCols+11][0]) begin
                base = (k - 2) * numCols;
                checkValue($sformatf("pattern %0h yOut", patMem[base]), patMem[base+12], yOut);
                checkValue($sformatf("pattern %0h yssOut", patMem[base]),
                           {60'd0, patMem[base+13][3:0]}, {60'd0, yssOut});
                checkValue($sformatf("pattern %0h ct", patMem[base]),
                           {63'd0, patMem[base+14][0]}, {63'd0, ct});
            end
        end

        // Arithmetic shift down keeps a set sign bit
        drive(makeWord({dstRamf, fnOr, srcDz}, 4'd0, 4'd8, 1'b0, 1'b0, '0, 1'b1, 1'b1),
              64'h8000_0000_0000_0001, '0);
        runOp(makeWord({dstRamd, fnOr, srcZa}, 4'd8, 4'd9, 1'b0, 1'b0, 13'h0100, 1'b1, 1'b1),
              '0, '0, yRes, stRes, ctRes);
        runOp(makeWord({dstRama, fnOr, srcZa}, 4'd9, 4'd9, 1'b0, 1'b0, '0, 1'b1, 1'b1),
              '0, '0, yRes, stRes, ctRes);
        checkValue("arith shift down", 64'hC000_0000_0000_0000, yRes);

        // 32-bit flags from carry 32 and from bit 31
        for (int t = 0; t < 2; t++) begin
            x = (t == 0) ? 64'h0000_0000_FFFF_FFFF : 64'h0000_0000_7FFF_FFFF;
            drive(makeWord({dstRamf, fnOr, srcDz}, 4'd0, 4'd10, 1'b0, 1'b0, '0, 1'b1, 1'b1),
                  x, '0);
            drive(makeWord({dstRamf, fnOr, srcDz}, 4'd0, 4'd11, 1'b0, 1'b0, '0, 1'b1, 1'b1),
                  64'd1, '0);
            runOp(makeWord({dstNop, fnAdd, srcAb}, 4'd10, 4'd11, 1'b0, 1'b1, '0, 1'b0, 1'b1),
                  '0, '0, yRes, stRes, ctRes);
            checkValue($sformatf("mode32 flags %0d", t), (t == 0) ? 64'hA : 64'h5,
                       {60'd0, stRes});
        end

        // Random add and subtract across all slices
        for (int iter = 0; iter < 6; iter++) begin
            a = {$random(seed), $random(seed)};
            b = {$random(seed), $random(seed)};
            drive(makeWord({dstRamf, fnOr, srcDz}, 4'd0, 4'd1, 1'b0, 1'b0, '0, 1'b1, 1'b1),
                  a, '0);
            drive(makeWord({dstRamf, fnOr, srcDz}, 4'd0, 4'd2, 1'b0, 1'b0, '0, 1'b1, 1'b1),
                  b, '0);
            for (int op = 0; op < 3; op++) begin
                for (int c = 0; c < 2; c++) begin
                    case (op)
                        0: begin fn = fnAdd;  x = a;  y = b;  end
                        1: begin fn = fnSubs; x = a;  y = ~b; end
                        default: begin fn = fnSubr; x = ~a; y = b; end
                    endcase
                    sumExp = addModel(x, y, c[0]);
                    runOp(makeWord({dstNop, fn, srcAb}, 4'd1, 4'd2, c[0], 1'b0, '0,
                                   1'b0, 1'b1), '0, '0, yRes, stRes, ctRes);
                    checkValue($sformatf("arith fn %0d cin %0d y", fn, c), sumExp[63:0], yRes);
                    checkValue($sformatf("arith fn %0d cin %0d flags", fn, c),
                               {60'd0, flagsModel(x, y, sumExp)}, {60'd0, stRes});
                end
            end
        end

        // Machine carry as carry in adds one
        runOp(makeWord({dstNop, fnOr, srcZa}, 4'd1, 4'd0, 1'b0, 1'b0, 13'h0010, 1'b0, 1'b1),
              '0, 4'b0010, yRes, stRes, ctRes);
        checkValue("status from yss", 64'h2, {60'd0, stRes});
        sumExp = addModel(a, b, 1'b1);
        runOp(makeWord({dstNop, fnAdd, srcAb}, 4'd1, 4'd2, 1'b0, 1'b0, 13'h1000, 1'b1, 1'b1),
              '0, '0, yRes, stRes, ctRes);
        checkValue("carry mux machine c", sumExp[63:0], yRes);

        // All sixteen CT codes against two machine status values
        for (int pass = 0; pass < 2; pass++) begin
            machExp  = (pass == 0) ? 4'b0110 : 4'b1001;
            sumExp   = addModel(a, b, 1'b0);
            microExp = flagsModel(a, b, sumExp);
            runOp(makeWord({dstNop, fnAdd, srcAb}, 4'd1, 4'd2, 1'b0, 1'b0, '0, 1'b1, 1'b0),
                  '0, '0, yRes, stRes, ctRes);
            runOp(makeWord({dstNop, fnOr, srcZa}, 4'd1, 4'd0, 1'b0, 1'b0, 13'h0010, 1'b0,
                           1'b1), '0, machExp, yRes, stRes, ctRes);
            for (int code = 0; code < 16; code++) begin
                runOp(makeWord({dstNop, fnOr, srcZa}, 4'd1, 4'd0, 1'b0, 1'b0, 13'(code),
                               1'b1, 1'b1), '0, '0, yRes, stRes, ctRes);
                checkValue($sformatf("ct code %0d", code),
                           {63'd0, ctModel(4'(code), microExp, machExp)}, {63'd0, ctRes});
            end
        end

        $display("Checks run %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/am2901.sv ====
`timescale 1ns/10ps
`default_nettype none

module am2901
    import sliceCorePkg::*;
(
    input  wire                   clk,
    input  wire  [8:0]            ialu,
    input  wire  [3:0]            aAddr,
    input  wire  [3:0]            bAddr,
    input  wire  [sliceWidth-1:0] d,
    input  wire                   cn,
    input  wire                   ram0In,
    input  wire                   ram3In,
    input  wire                   q0In,
    input  wire                   q3In,
    output logic [sliceWidth-1:0] y,
    output logic                  ram0Out,
    output logic                  ram3Out,
    output logic                  q0Out,
    output logic                  q3Out,
    output logic                  gN,
    output logic                  pN,
    output logic                  cn4,
    output logic                  ovr,
    output logic                  f3,
    output logic                  fZero
);

    logic [sliceWidth-1:0] regFile [0:15];
    logic [sliceWidth-1:0] qReg;
    logic [sliceWidth-1:0] aData;
    logic [sliceWidth-1:0] bData;
    logic [sliceWidth-1:0] r;
    logic [sliceWidth-1:0] s;
    logic [sliceWidth-1:0] opR;
    logic [sliceWidth-1:0] opS;
    logic [sliceWidth-1:0] f;
    logic [sliceWidth-1:0] gBit;
    logic [sliceWidth-1:0] pBit;
    logic [sliceWidth:0]   sum;
    logic [sliceWidth-1:0] lowSum;
    logic [sliceWidth-1:0] ramData;
    logic                  ramWe;
    logic [2:0]            src;
    logic [2:0]            fn;
    logic [2:0]            dst;

    assign src = ialu[2:0];
    assign fn  = ialu[5:3];
    assign dst = ialu[8:6];

    // Two read ports, both asynchronous
    assign aData = regFile[aAddr];
    assign bData = regFile[bAddr];

    // Operand pair
    always_comb begin
        case (src)
            srcAq: begin r = aData; s = qReg;  end
            srcAb: begin r = aData; s = bData; end
            srcZq: begin r = '0;    s = qReg;  end
            srcZb: begin r = '0;    s = bData; end
            srcZa: begin r = '0;    s = aData; end
            srcDa: begin r = d;     s = aData; end
            srcDq: begin r = d;     s = qReg;  end
            default: begin r = d;   s = '0;    end
        endcase
    end

    // Subtraction is complement plus carry in
    always_comb begin
        opR = (fn == fnSubr) ? ~r : r;
        opS = (fn == fnSubs) ? ~s : s;
    end

    assign sum    = {1'b0, opR} + {1'b0, opS} + cn;
    // Carry into the sign bit, for overflow
    assign lowSum = {1'b0, opR[sliceWidth-2:0]} + {1'b0, opS[sliceWidth-2:0]} + cn;

    always_comb begin
        case (fn)
            fnAdd, fnSubr, fnSubs: f = sum[sliceWidth-1:0];
            fnOr:    f = r | s;
            fnAnd:   f = r & s;
            fnNotRs: f = ~r & s;
            fnExor:  f = r ^ s;
            default: f = ~(r ^ s);
        endcase
    end

    // Lookahead terms from the adder operands
    assign gBit = opR & opS;
    assign pBit = opR | opS;
    assign gN   = ~(gBit[3] | (pBit[3] & gBit[2]) | (pBit[3] & pBit[2] & gBit[1]) |
                    (pBit[3] & pBit[2] & pBit[1] & gBit[0]));
    assign pN   = ~&pBit;

    assign cn4   = sum[sliceWidth];
    assign ovr   = lowSum[sliceWidth-1] ^ sum[sliceWidth];
    assign f3    = f[sliceWidth-1];
    assign fZero = (f == '0);

    // A passes to Y only for RAMA
    assign y = (dst == dstRama) ? aData : f;

    // Shift ports, each end always shows its edge bit
    assign ram0Out = f[0];
    assign ram3Out = f[sliceWidth-1];
    assign q0Out   = qReg[0];
    assign q3Out   = qReg[sliceWidth-1];

    // Register file write data, F straight or shifted
    always_comb begin
        ramData = f;
        ramWe   = 1'b1;
        case (dst)
            dstQreg, dstNop:   ramWe   = 1'b0;
            dstRamqd, dstRamd: ramData = {ram3In, f[sliceWidth-1:1]};
            dstRamqu, dstRamu: ramData = {f[sliceWidth-2:0], ram0In};
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (ramWe) begin
            regFile[bAddr] <= ramData;
        end
        // Q loads F or shifts along with the RAM
        case (dst)
            dstQreg:  qReg <= f;
            dstRamqd: qReg <= {q3In, qReg[sliceWidth-1:1]};
            dstRamqu: qReg <= {qReg[sliceWidth-2:0], q0In};
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/am2902.sv ====
`timescale 1ns/10ps
`default_nettype none

module am2902 (
    input  wire        cn,
    input  wire  [3:0] gN,
    input  wire  [3:0] pN,
    output logic       cnx,
    output logic       cny,
    output logic       cnz,
    output logic       gGroupN,
    output logic       pGroupN
);

    logic [3:0] g;
    logic [3:0] p;

    // Inputs arrive active low
    assign g = ~gN;
    assign p = ~pN;

    // Carries into positions 1, 2 and 3
    assign cnx = g[0] | (p[0] & cn);
    assign cny = g[1] | (p[1] & g[0]) | (p[1] & p[0] & cn);
    assign cnz = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0]) | (p[2] & p[1] & p[0] & cn);

    // Group terms for the next lookahead level
    assign gGroupN = ~(g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1]) |
                       (p[3] & p[2] & p[1] & g[0]));
    assign pGroupN = ~&p;

endmodule

`default_nettype wire

// ==== hdl/am2904.sv ====
`timescale 1ns/10ps
`default_nettype none

module am2904
    import sliceCorePkg::*;
(
    input  wire         clk,
    input  wire         rstN,
    input  wire  [12:0] iss,
    input  wire         nCem,
    input  wire         nCen,
    input  wire statusT aluFlags,
    input  wire statusT yss,
    input  wire         cin,
    input  wire         shiftEn,
    input  wire         ram0Out,
    input  wire         ram63Out,
    input  wire         q0Out,
    input  wire         q63Out,
    output logic        c0,
    output logic        ram0In,
    output logic        ram63In,
    output logic        q0In,
    output logic        q63In,
    output statusT      machStatus,
    output logic        ct
);

    statusT microStatus;
    statusT testStatus;
    logic   testBit;
    logic   shiftUp;
    logic   rFill;
    logic   qFill;

    // Micro and machine status registers
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            microStatus <= '0;
            machStatus  <= '0;
        end else begin
            if (!nCen) begin
                microStatus <= aluFlags;
            end
            // Bit 4 picks the Y bus over the ALU flags
            if (!nCem) begin
                machStatus <= iss[4] ? yss : aluFlags;
            end
        end
    end

    // Condition test, bit 3 selects machine status, bit 0 inverts
    always_comb begin
        testStatus = iss[3] ? machStatus : microStatus;
        case (iss[2:1])
            2'd0:    testBit = testStatus.z;
            2'd1:    testBit = testStatus.c;
            2'd2:    testBit = testStatus.n;
            default: testBit = testStatus.ovr;
        endcase
        ct = testBit ^ iss[0];
    end

    // Carry in for slice 0
    always_comb begin
        case (iss[12:11])
            2'd0:    c0 = cin;
            2'd1:    c0 = microStatus.c;
            2'd2:    c0 = machStatus.c;
            default: c0 = ~machStatus.c;
        endcase
    end

    // Fill bits for RAM and Q, set by the linkage code
    always_comb begin
        shiftUp = iss[10];
        rFill   = 1'b0;
        qFill   = 1'b0;
        case (iss[8:6])
            // One fill
            3'd1: begin
                rFill = 1'b1;
                qFill = 1'b1;
            end
            // Single-word rotate
            3'd2: begin
                rFill = shiftUp ? ram63Out : ram0Out;
                qFill = shiftUp ? q63Out : q0Out;
            end
            // Rotate through R and Q as one long word
            3'd3: begin
                rFill = shiftUp ? q63Out : q0Out;
                qFill = shiftUp ? ram63Out : ram0Out;
            end
            // Arithmetic, sign kept on the way down, Q takes the R bit
            3'd4: begin
                rFill = shiftUp ? q63Out : ram63Out;
                qFill = shiftUp ? 1'b0 : ram0Out;
            end
            // Machine carry into both
            3'd5: begin
                rFill = machStatus.c;
                qFill = machStatus.c;
            end
            default: ;
        endcase
        // Only the end the word moves away from gets the fill
        ram0In  = shiftEn & shiftUp & rFill;
        ram63In = shiftEn & ~shiftUp & rFill;
        q0In    = shiftEn & shiftUp & qFill;
        q63In   = shiftEn & ~shiftUp & qFill;
    end

endmodule

`default_nettype wire

// ==== hdl/busOutReg.sv ====
`timescale 1ns/10ps
`default_nettype none

module busOutReg
    import sliceCorePkg::*;
(
    input  wire                  clk,
    input  wire                  rstN,
    input  wire [dataWidth-1:0]  yNext,
    input  wire statusT          yssNext,
    input  wire                  ctNext,
    output logic [dataWidth-1:0] yOut,
    output statusT               yssOut,
    output logic                 ct
);

    // Output buses, cleared so the pins read zero out of reset
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            yOut   <= '0;
            yssOut <= '0;
            ct     <= 1'b0;
        end else begin
            yOut   <= yNext;
            yssOut <= yssNext;
            ct     <= ctNext;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/datapath.sv ====
`timescale 1ns/10ps
`default_nettype none

module datapath
    import sliceCorePkg::*;
(
    input  wire                  clk,
    input  wire                  rstN,
    input  wire microWordT       uWord,
    input  wire [dataWidth-1:0]  dReg,
    input  wire statusT          yssReg,
    output logic [dataWidth-1:0] y,
    output statusT               yss,
    output logic                 ct
);

    // Carry into each slice, top bit is carry out of bit 63
    logic [numSlices:0]   sliceCarry;
    logic [numSlices-1:0] gNS, pNS, cn4S, ovrS, f3S, fZeroS;
    logic [numSlices-1:0] ram0OutS, ram3OutS, q0OutS, q3OutS;
    logic [numSlices-1:0] ram0InS, ram3InS, q0InS, q3InS;
    logic [3:0]           groupGN;
    logic [3:0]           groupPN;
    logic                 ram0In, ram63In, q0In, q63In;
    logic                 zero32;
    logic                 zero64;
    statusT               aluFlags;

    genvar i;
    generate
        for (i = 0; i < numSlices; i++) begin : gSlice
            am2901 uSlice (
                .clk(clk), .ialu(uWord.ialu), .aAddr(uWord.aAddr), .bAddr(uWord.bAddr),
                .d(dReg[i*sliceWidth +: sliceWidth]), .cn(sliceCarry[i]),
                .ram0In(ram0InS[i]), .ram3In(ram3InS[i]), .q0In(q0InS[i]), .q3In(q3InS[i]),
                .y(y[i*sliceWidth +: sliceWidth]),
                .ram0Out(ram0OutS[i]), .ram3Out(ram3OutS[i]),
                .q0Out(q0OutS[i]), .q3Out(q3OutS[i]),
                .gN(gNS[i]), .pN(pNS[i]), .cn4(cn4S[i]), .ovr(ovrS[i]),
                .f3(f3S[i]), .fZero(fZeroS[i])
            );
        end

        // First lookahead level, four slices per group
        for (i = 0; i < numSlices / 4; i++) begin : gLook
            am2902 uLook (
                .cn(sliceCarry[4*i]), .gN(gNS[4*i +: 4]), .pN(pNS[4*i +: 4]),
                .cnx(sliceCarry[4*i+1]), .cny(sliceCarry[4*i+2]), .cnz(sliceCarry[4*i+3]),
                .gGroupN(groupGN[i]), .pGroupN(groupPN[i])
            );
        end
    endgenerate

    // Second level gives carries 16, 32 and 48
    am2902 uLookTop (
        .cn(sliceCarry[0]), .gN(groupGN), .pN(groupPN),
        .cnx(sliceCarry[4]), .cny(sliceCarry[8]), .cnz(sliceCarry[12]),
        .gGroupN(), .pGroupN()
    );

    assign sliceCarry[numSlices] = cn4S[numSlices-1];

    // Neighbour shift links, the outer ends come from the status unit
    assign ram0InS = {ram3OutS[numSlices-2:0], ram0In};
    assign ram3InS = {ram63In, ram0OutS[numSlices-1:1]};
    assign q0InS   = {q3OutS[numSlices-2:0], q0In};
    assign q3InS   = {q63In, q0OutS[numSlices-1:1]};

    assign zero32 = &fZeroS[halfTopSlice:0];
    assign zero64 = &fZeroS;

    // Flags of the low word or of the full word
    always_comb begin
        aluFlags.z   = uWord.mode32 ? zero32 : zero64;
        aluFlags.n   = uWord.mode32 ? f3S[halfTopSlice] : f3S[numSlices-1];
        aluFlags.c   = uWord.mode32 ? sliceCarry[halfTopSlice+1] : sliceCarry[numSlices];
        aluFlags.ovr = uWord.mode32 ? ovrS[halfTopSlice] : ovrS[numSlices-1];
    end

    am2904 uStatus (
        .clk(clk), .rstN(rstN), .iss(uWord.iss), .nCem(uWord.nCem), .nCen(uWord.nCen),
        .aluFlags(aluFlags), .yss(yssReg), .cin(uWord.cin),
        .shiftEn(uWord.ialu[8]), // Set for all four shift destinations
        .ram0Out(ram0OutS[0]), .ram63Out(ram3OutS[numSlices-1]),
        .q0Out(q0OutS[0]), .q63Out(q3OutS[numSlices-1]),
        .c0(sliceCarry[0]), .ram0In(ram0In), .ram63In(ram63In), .q0In(q0In), .q63In(q63In),
        .machStatus(yss), .ct(ct)
    );

endmodule

`default_nettype wire

// ==== hdl/microWordReg.sv ====
`timescale 1ns/10ps
`default_nettype none

module microWordReg
    import sliceCorePkg::*;
(
    input  wire                  clk,
    input  wire                  rstN,
    input  wire microWordT       microIn,
    input  wire [dataWidth-1:0]  dIn,
    input  wire statusT          yssIn,
    output microWordT            uWord,
    output logic [dataWidth-1:0] dReg,
    output statusT               yssReg
);

    microWordT nextWord;

    // Shift direction of the status unit follows ALU destination bit 7
    // Board wiring, so the microprogram only sets it once
    always_comb begin
        nextWord         = microIn;
        nextWord.iss[10] = microIn.ialu[7];
    end

    // Control word, idles as NOP out of reset
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            uWord <= nopMicroWord;
        end else begin
            uWord <= nextWord;
        end
    end

    // Operand and status bus data, aligned with the microword
    always_ff @(posedge clk) begin
        dReg   <= dIn;
        yssReg <= yssIn;
    end

endmodule

`default_nettype wire

// ==== hdl/slice64Core.sv ====
`timescale 1ns/10ps
`default_nettype none

module slice64Core
    import sliceCorePkg::*;
(
    input  wire                  clk,
    input  wire                  rstN,
    input  wire microWordT       microIn,
    input  wire [dataWidth-1:0]  dIn,
    input  wire statusT          yssIn,
    output logic [dataWidth-1:0] yOut,
    output statusT               yssOut,
    output logic                 ct
);

    microWordT            uWord;
    logic [dataWidth-1:0] dReg;
    statusT               yssReg;
    logic [dataWidth-1:0] yNext;
    statusT               yssNext;
    logic                 ctNext;

    // Pipeline register in front of the slices
    microWordReg uInReg (
        .clk(clk), .rstN(rstN), .microIn(microIn), .dIn(dIn), .yssIn(yssIn),
        .uWord(uWord), .dReg(dReg), .yssReg(yssReg)
    );

    datapath uDatapath (
        .clk(clk), .rstN(rstN), .uWord(uWord), .dReg(dReg), .yssReg(yssReg),
        .y(yNext), .yss(yssNext), .ct(ctNext)
    );

    // Results leave one edge after the microword is taken
    busOutReg uOutReg (
        .clk(clk), .rstN(rstN), .yNext(yNext), .yssNext(yssNext), .ctNext(ctNext),
        .yOut(yOut), .yssOut(yssOut), .ct(ct)
    );

endmodule

`default_nettype wire

// ==== hdl/sliceCorePkg.sv ====
`default_nettype none

package sliceCorePkg;

    // Datapath geometry
    localparam int dataWidth    = 64;
    localparam int sliceWidth   = 4;
    localparam int numSlices    = dataWidth / sliceWidth;
    // Slice holding bits 31:28, top of the 32-bit word
    localparam int halfTopSlice = 7;

    // ALU source operand pairs, named R then S
    localparam logic [2:0] srcAq = 3'd0;
    localparam logic [2:0] srcAb = 3'd1;
    localparam logic [2:0] srcZq = 3'd2;
    localparam logic [2:0] srcZb = 3'd3;
    localparam logic [2:0] srcZa = 3'd4;
    localparam logic [2:0] srcDa = 3'd5;
    localparam logic [2:0] srcDq = 3'd6;
    localparam logic [2:0] srcDz = 3'd7;

    // ALU functions
    localparam logic [2:0] fnAdd   = 3'd0;
    localparam logic [2:0] fnSubr  = 3'd1; // S minus R
    localparam logic [2:0] fnSubs  = 3'd2; // R minus S
    localparam logic [2:0] fnOr    = 3'd3;
    localparam logic [2:0] fnAnd   = 3'd4;
    localparam logic [2:0] fnNotRs = 3'd5;
    localparam logic [2:0] fnExor  = 3'd6;
    localparam logic [2:0] fnExnor = 3'd7;

    // Destination control, bit 2 set means a shift, bit 1 gives up or down
    localparam logic [2:0] dstQreg  = 3'd0;
    localparam logic [2:0] dstNop   = 3'd1;
    localparam logic [2:0] dstRama  = 3'd2;
    localparam logic [2:0] dstRamf  = 3'd3;
    localparam logic [2:0] dstRamqd = 3'd4;
    localparam logic [2:0] dstRamd  = 3'd5;
    localparam logic [2:0] dstRamqu = 3'd6;
    localparam logic [2:0] dstRamu  = 3'd7;

    typedef struct packed {
        logic [8:0]  ialu;   // Destination 8:6, function 5:3, source 2:0
        logic [3:0]  aAddr;
        logic [3:0]  bAddr;
        logic        cin;
        logic        mode32; // Flags taken from bit 31 instead of bit 63
        logic [12:0] iss;    // Status and shift instruction
        logic        nCem;   // Machine status load, active low
        logic        nCen;   // Micro status load, active low
    } microWordT;

    // Same bit order as the Yss bus
    typedef struct packed {
        logic z;
        logic n;
        logic c;
        logic ovr;
    } statusT;

    // Idle word, writes nothing and loads no status
    localparam microWordT nopMicroWord = '{
        ialu:   {dstNop, fnOr, srcZa},
        aAddr:  4'd0,
        bAddr:  4'd0,
        cin:    1'b0,
        mode32: 1'b0,
        iss:    13'd0,
        nCem:   1'b1,
        nCen:   1'b1
    };

endpackage

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the slice64Core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tbSlice64Core -f src.f -o simTb \
    && simOut="$(./obj_dir/simTb)" \
    && printf '%s\n' "$simOut" \
    && printf '%s\n' "$simOut" | grep -q "TESTS PASSED" \
    && exit 0 \
    || exit 1

// ==== src.f ====
hdl/sliceCorePkg.sv
hdl/microWordReg.sv
hdl/am2901.sv
hdl/am2902.sv
hdl/am2904.sv
hdl/datapath.sv
hdl/busOutReg.sv
hdl/slice64Core.sv
dv/tbSlice64Core.sv
